/* flist.f */
+incdir+hdl
hdl/blit_pkg.sv
hdl/blit_rect_gen.sv
hdl/blit_addr_calc.sv
hdl/blit_mem_fetch.sv
hdl/blit_colour_lookup.sv
hdl/blit_top.sv
testbench/blit_axi_mem.sv
testbench/blit_tb.sv

/* Makefile */
# Verilator build and run for the sprite blitter testbench

VERILATOR ?= verilator
TOP       ?= blit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) hdl/blit_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Verification passed$$'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/blit_tb.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_tb;

    localparam int N_TESTS = 7;

    logic clk;
    logic rst;
    logic cmd_valid;
    logic cmd_ready;
    blit_pkg::blit_cmd_t cmd;
    logic ct_we;
    logic [`BLIT_CT_ADDR_W-1:0] ct_addr;
    logic [`BLIT_COLOUR_W-1:0] ct_data;
    logic arvalid;
    logic arready;
    logic [`BLIT_ADDR_W-1:0] araddr;
    logic rvalid;
    logic rready;
    logic [`BLIT_DATA_W-1:0] rdata;
    logic pix_valid;
    logic pix_ready;
    blit_pkg::pixel_t pix;
    logic mem_stall;

    blit_pkg::blit_cmd_t cmds [N_TESTS];  // command table
    int exp_pix [N_TESTS];
    int exp_reads [N_TESTS];               // -1 when not fixed by hand
    bit rand_rdy [N_TESTS];

    logic [31:0] lfsr_q = 32'hd56a_bf04;
    logic [`BLIT_COLOUR_W-1:0] ct_model [`BLIT_CT_DEPTH];
    blit_pkg::pixel_t exp_q [$];
    logic [31:0] last_waddr = 32'hffff_ffff;
    int model_reads = 0;
    int dut_reads = 0;
    int errors = 0;
    int tests_done = 0;
    int pix_cnt = 0;
    int errs_before = 0;
    int cycles = 0;
    int limit = 0;
    bit running = 0;
    bit rand_mode = 0;

    blit_top u_blit_top (.*);

    blit_axi_mem u_mem (
        .clk(clk), .rst(rst), .stall(mem_stall), .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .rvalid(rvalid), .rready(rready), .rdata(rdata)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic blit_pkg::blit_cmd_t make_cmd(
        input logic [31:0] base, input int sw, input int sx, input int sy,
        input int dx, input int dy, input int w, input int h,
        input int scx, input int scy, input bit mx, input bit my,
        input blit_pkg::ct_type_e bpp, input bit ct
    );
        blit_pkg::blit_cmd_t c;
        c.sheet_base  = base;
        c.sheet_width = sw[15:0];
        c.src_x       = sx[15:0];
        c.src_y       = sy[15:0];
        c.dst_x       = dx[15:0];
        c.dst_y       = dy[15:0];
        c.width       = w[15:0];
        c.height      = h[15:0];
        c.scale_x     = scx[15:0];
        c.scale_y     = scy[15:0];
        c.mirror_x    = mx;
        c.mirror_y    = my;
        c.ct_type     = bpp;
        c.use_ct      = ct;
        return c;
    endfunction

    // sheet coordinate for screen step i
    function automatic int sheet_coord(input int src, input logic signed [15:0] scale,
                                       input int i);
        int s;
        s = scale;
        if (s < 0) return src - i * s;
        if (s == 0) return src + i;
        return src + i / s;
    endfunction

    task automatic model_cmd(input blit_pkg::blit_cmd_t c);
        int sx;
        int sy;
        int bpp;
        logic [31:0] bitpos;
        logic [31:0] waddr;
        logic [31:0] val;
        blit_pkg::pixel_t p;
        bpp = int'(c.ct_type);
        for (int r = 0; r < int'(c.height); r++) begin
            for (int j = 0; j < int'(c.width); j++) begin
                sx = sheet_coord(int'(c.src_x), c.scale_x, j);
                sy = sheet_coord(int'(c.src_y), c.scale_y, r);
                bitpos = (sx + int'(c.sheet_width) * sy) * bpp;
                waddr = c.sheet_base + (bitpos / 32) * 4;
                if (waddr != last_waddr) model_reads++;  // word change means a bus read
                last_waddr = waddr;
                val = (u_mem.mem[waddr[11:2]] >> (bitpos % 32)) & ((32'd1 << bpp) - 1);
                p.colour = c.use_ct ? ct_model[val[7:0]] : val[15:0];
                p.x = c.mirror_x ? c.dst_x + c.width - 1 - j : c.dst_x + j;
                p.y = c.mirror_y ? c.dst_y + c.height - 1 - r : c.dst_y + r;
                p.last = (r == int'(c.height) - 1) && (j == int'(c.width) - 1);
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic check_pixel(input blit_pkg::pixel_t got, input blit_pkg::pixel_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: got c=%h x=%0d y=%0d l=%b, expected c=%h x=%0d y=%0d l=%b",
                     $time, got.colour, got.x, got.y, got.last,
                     exp.colour, exp.x, exp.y, exp.last);
        end
    endtask

    task automatic check_count(input logic [`BLIT_COORD_W-1:0] got,
                               input logic [`BLIT_COORD_W-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure and AXI stalls
    always @(posedge clk) begin
        #10;
        pix_ready = rand_mode ? lfsr_bit() : 1'b1;
        mem_stall = lfsr_bit() & lfsr_bit();
    end

    always @(posedge clk) begin
        if (!rst && arvalid && arready) dut_reads++;
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: pipeline stuck after %0d cycles, %0d pixels still expected",
                         cycles, exp_q.size());
                $display("Verification failed");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && pix_valid && pix_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected pixel at x=%0d y=%0d with no command pending",
                         pix.x, pix.y);
            end else begin
                check_pixel(pix, exp_q.pop_front());
                pix_cnt++;
                if (pix.last) begin
                    check_count(pix_cnt, exp_pix[tests_done], "pixel");
                    $display("test %0d: %0d pixels, %s", tests_done, pix_cnt,
                             (errors == errs_before) ? "ok" : "mismatch");
                    errs_before = errors;
                    pix_cnt = 0;
                    tests_done++;
                end
            end
        end
    end

    initial begin
        int reads_before;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        ct_we = 1'b0;
        ct_addr = '0;
        ct_data = '0;
        pix_ready = 1'b1;
        mem_stall = 1'b0;
        reads_before = 0;
        for (int i = 0; i < 1024; i++) u_mem.mem[i] = rand_bits(32);
        for (int i = 0; i < `BLIT_CT_DEPTH; i++) ct_model[i] = rand_bits(16);

        cmds[0] = make_cmd('h000, 8, 1, 1, 10, 20, 4, 3, 1, 1, 0, 0, blit_pkg::BPP_16, 0);
        cmds[1] = make_cmd('h100, 32, 2, 1, 40, 5, 6, 2, 2, 1, 1, 0, blit_pkg::BPP_8, 0);
        cmds[2] = make_cmd('h200, 32, 0, 0, 0, 0, 4, 3, -2, -2, 0, 0, blit_pkg::BPP_4, 1);
        cmds[3] = cmds[2];
        cmds[4] = make_cmd('h800, 64, 0, 0, 3, 3, 40, 2, 1, 1, 0, 0, blit_pkg::BPP_1, 0);
        cmds[5] = make_cmd('hc00, 16, 0, 0, 7, 9, 16, 2, 1, 1, 0, 0, blit_pkg::BPP_2, 1);
        cmds[6] = make_cmd('h300, 8, 2, 0, 50, 60, 3, 2, 0, 1, 0, 1, blit_pkg::BPP_16, 0);
        exp_pix = '{12, 12, 12, 12, 80, 32, 6};
        exp_reads = '{-1, -1, -1, -1, 4, 2, -1};
        rand_rdy = '{0, 0, 0, 1, 0, 0, 0};
        for (int t = 0; t < N_TESTS; t++) limit += exp_pix[t];
        limit = limit * 20 + 200;

        repeat (2) @(posedge clk);
        #10 rst = 1'b0;
        for (int i = 0; i < `BLIT_CT_DEPTH; i++) begin
            @(posedge clk);
            #10;
            ct_we = 1'b1;
            ct_addr = i[7:0];
            ct_data = ct_model[i];
        end
        @(posedge clk);
        #10 ct_we = 1'b0;
        running = 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            model_cmd(cmds[t]);
            if (exp_reads[t] >= 0) begin
                while (tests_done != t) begin  // drain so every read belongs to this command
                    @(posedge clk);
                    #10;
                end
                reads_before = dut_reads;
            end
            rand_mode = rand_rdy[t];
            cmd = cmds[t];
            cmd_valid = 1'b1;
            while (!cmd_ready) begin
                @(posedge clk);
                #10;
            end
            @(posedge clk);
            #10 cmd_valid = 1'b0;
            if (exp_reads[t] >= 0) begin
                while (tests_done != t + 1) begin
                    @(posedge clk);
                    #10;
                end
                check_count(dut_reads - reads_before, exp_reads[t], "AXI read");
            end
        end

        wait (tests_done == N_TESTS);
        @(posedge clk);
        check_count(dut_reads, model_reads, "AXI read");
        $display("%0d tests run, %0d errors, %0d AXI reads", tests_done, errors, dut_reads);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* testbench/blit_axi_mem.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_axi_mem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,   // holds off arready this cycle
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`BLIT_ADDR_W-1:0] araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`BLIT_DATA_W-1:0] rdata
);

    localparam int MEM_WORDS = 1024;

    logic [`BLIT_DATA_W-1:0] mem [MEM_WORDS];  // filled by the testbench

    assign arready = !stall && !rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
            rdata  <= mem[araddr[11:2]];
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

/* hdl/blit_top.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  blit_pkg::blit_cmd_t        cmd,
    input  logic                       ct_we,
    input  logic [`BLIT_CT_ADDR_W-1:0] ct_addr,
    input  logic [`BLIT_COLOUR_W-1:0]  ct_data,
    output logic                       arvalid,
    input  logic                       arready,
    output logic [`BLIT_ADDR_W-1:0]    araddr,
    input  logic                       rvalid,
    output logic                       rready,
    input  logic [`BLIT_DATA_W-1:0]    rdata,
    output logic                       pix_valid,
    input  logic                       pix_ready,
    output blit_pkg::pixel_t           pix
);

    blit_pkg::sheet_pos_t pos;      // walker to address stage
    logic                 pos_valid;
    logic                 pos_ready;
    blit_pkg::fetch_req_t req;      // address stage to fetch
    logic                 req_valid;
    logic                 req_ready;
    blit_pkg::texel_t     texel;    // fetch to colour lookup
    logic                 tex_valid;
    logic                 tex_ready;

    blit_rect_gen u_rect_gen (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .pos_valid (pos_valid),
        .pos_ready (pos_ready),
        .pos       (pos)
    );

    blit_addr_calc u_addr_calc (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pos_valid),
        .in_ready  (pos_ready),
        .pos       (pos),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .req       (req)
    );

    blit_mem_fetch u_mem_fetch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .req       (req),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .out_valid (tex_valid),
        .out_ready (tex_ready),
        .texel     (texel)
    );

    blit_colour_lookup u_colour_lookup (
        .clk       (clk),
        .rst       (rst),
        .ct_we     (ct_we),
        .ct_addr   (ct_addr),
        .ct_data   (ct_data),
        .in_valid  (tex_valid),
        .in_ready  (tex_ready),
        .texel     (texel),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix       (pix)
    );

endmodule

/* hdl/blit_colour_lookup.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_colour_lookup (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ct_we,
    input  logic [`BLIT_CT_ADDR_W-1:0] ct_addr,
    input  logic [`BLIT_COLOUR_W-1:0] ct_data,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  blit_pkg::texel_t          texel,
    output logic                      pix_valid,
    input  logic                      pix_ready,
    output blit_pkg::pixel_t          pix
);

    logic [`BLIT_COLOUR_W-1:0] ct_mem [`BLIT_CT_DEPTH];  // RGB565 entries
    logic [`BLIT_COLOUR_W-1:0] ct_entry;
    logic                      in_hs;

    always_ff @(posedge clk) begin
        if (ct_we) ct_mem[ct_addr] <= ct_data;
    end

    assign ct_entry = ct_mem[texel.value[`BLIT_CT_ADDR_W-1:0]];  // low byte indexes
    assign in_ready = !pix_valid || pix_ready;
    assign in_hs    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else if (in_hs) begin
            pix_valid <= 1'b1;
        end else if (pix_ready) begin
            pix_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_hs) begin
            pix.colour <= texel.use_ct ? ct_entry : texel.value;
            pix.x      <= texel.screen_x;
            pix.y      <= texel.screen_y;
            pix.last   <= texel.last;
        end
    end

endmodule

/* hdl/blit_mem_fetch.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_mem_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  blit_pkg::fetch_req_t    req,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [`BLIT_ADDR_W-1:0] araddr,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [`BLIT_DATA_W-1:0] rdata,
    output logic                    out_valid,
    input  logic                    out_ready,
    output blit_pkg::texel_t        texel
);

    blit_pkg::fetch_state_e  state;
    blit_pkg::fetch_req_t    req_q;        // request in flight
    logic                    cache_valid;
    logic [`BLIT_ADDR_W-1:0] cache_addr;
    logic [`BLIT_DATA_W-1:0] cache_word;
    logic                    in_hs;
    logic                    hit;

    // pull one lsb-first field out of a word
    function automatic blit_pkg::texel_t extract(
        input logic [`BLIT_DATA_W-1:0] word,
        input blit_pkg::fetch_req_t    r
    );
        logic [`BLIT_DATA_W-1:0] shifted;
        logic [`BLIT_DATA_W-1:0] mask;
        blit_pkg::texel_t        t;
        shifted    = word >> r.bit_offset;
        mask       = ({{(`BLIT_DATA_W-1){1'b0}}, 1'b1} << r.ct_type) - 1'b1;
        t.value    = shifted[`BLIT_COLOUR_W-1:0] & mask[`BLIT_COLOUR_W-1:0];
        t.use_ct   = r.use_ct;
        t.screen_x = r.screen_x;
        t.screen_y = r.screen_y;
        t.last     = r.last;
        return t;
    endfunction

    assign in_ready  = (state == blit_pkg::FETCH_IDLE);
    assign arvalid   = (state == blit_pkg::FETCH_ADDR);
    assign rready    = (state == blit_pkg::FETCH_DATA);
    assign out_valid = (state == blit_pkg::FETCH_HOLD);
    assign araddr    = {req_q.word_addr[`BLIT_ADDR_W-1:2], 2'b00};  // word aligned
    assign in_hs     = in_valid && in_ready;
    assign hit       = cache_valid && (cache_addr == req.word_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= blit_pkg::FETCH_IDLE;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                blit_pkg::FETCH_IDLE: begin
                    if (in_hs) state <= hit ? blit_pkg::FETCH_HOLD : blit_pkg::FETCH_ADDR;
                end
                blit_pkg::FETCH_ADDR: if (arready) state <= blit_pkg::FETCH_DATA;
                blit_pkg::FETCH_DATA: begin
                    if (rvalid) begin
                        state       <= blit_pkg::FETCH_HOLD;
                        cache_valid <= 1'b1;
                    end
                end
                blit_pkg::FETCH_HOLD: if (out_ready) state <= blit_pkg::FETCH_IDLE;
                default: state <= blit_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_hs) begin
            req_q <= req;
            if (hit) texel <= extract(cache_word, req);  // no bus read needed
        end
        if (state == blit_pkg::FETCH_DATA && rvalid) begin
            cache_word <= rdata;
            cache_addr <= req_q.word_addr;
            texel      <= extract(rdata, req_q);
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

/* hdl/blit_addr_calc.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_addr_calc (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  blit_pkg::sheet_pos_t pos,
    output logic                 out_valid,
    input  logic                 out_ready,
    output blit_pkg::fetch_req_t req
);

    typedef enum logic [1:0] {
        EMPTY,
        FULL,
        SKID
    } skid_state_e;

    skid_state_e              state;
    blit_pkg::fetch_req_t     calc;     // request built from pos
    blit_pkg::fetch_req_t     skid_q;   // overflow entry
    logic [`BLIT_ADDR_W-1:0]  index;
    logic [`BLIT_ADDR_W-1:0]  bit_pos;
    logic                     in_hs;
    logic                     out_hs;

    assign index   = pos.sheet_x + pos.sheet_width * pos.sheet_y;  // linear pixel index
    assign bit_pos = index * pos.ct_type;

    always_comb begin
        calc.word_addr  = pos.sheet_base + {bit_pos[`BLIT_ADDR_W-1:5], 2'b00};
        calc.bit_offset = bit_pos[4:0];
        calc.ct_type    = pos.ct_type;
        calc.use_ct     = pos.use_ct;
        calc.screen_x   = pos.screen_x;
        calc.screen_y   = pos.screen_y;
        calc.last       = pos.last;
    end

    assign in_ready  = (state != SKID);
    assign out_valid = (state != EMPTY);
    assign in_hs     = in_valid && in_ready;
    assign out_hs    = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY: if (in_hs) state <= FULL;
                FULL: begin
                    if (in_hs && !out_hs) state <= SKID;
                    else if (!in_hs && out_hs) state <= EMPTY;
                end
                SKID: if (out_ready) state <= FULL;
                default: state <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SKID) begin
            if (out_ready) req <= skid_q;  // drain skid into output
        end else if (in_hs) begin
            if (state == FULL && !out_hs) skid_q <= calc;
            else req <= calc;
        end
    end

    a_skid_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(req));

endmodule

/* hdl/blit_rect_gen.sv */
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_rect_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  blit_pkg::blit_cmd_t    cmd,
    output logic                   pos_valid,
    input  logic                   pos_ready,
    output blit_pkg::sheet_pos_t   pos
);

    blit_pkg::rect_state_e    state;
    blit_pkg::blit_cmd_t      cmd_q;     // latched command
    logic [`BLIT_COORD_W-1:0] x;         // step index within the row
    logic [`BLIT_COORD_W-1:0] y;
    logic [`BLIT_COORD_W-1:0] sub_x;     // repeat counters for upscale
    logic [`BLIT_COORD_W-1:0] sub_y;
    logic [`BLIT_COORD_W-1:0] ss_x;      // current sheet position
    logic [`BLIT_COORD_W-1:0] ss_y;
    logic [`BLIT_COORD_W-1:0] nxt_sub_x;
    logic [`BLIT_COORD_W-1:0] nxt_sub_y;
    logic [`BLIT_COORD_W-1:0] nxt_ss_x;
    logic [`BLIT_COORD_W-1:0] nxt_ss_y;
    logic [`BLIT_COORD_W-1:0] max_x;
    logic [`BLIT_COORD_W-1:0] max_y;
    logic                     x_end;
    logic                     y_end;
    logic                     pos_hs;

    function automatic logic [`BLIT_COORD_W-1:0] scale_mag(
        input logic signed [`BLIT_COORD_W-1:0] s
    );
        if (s < 0) return -s;
        if (s == 0) return 1;  // zero behaves as a plain copy
        return s;
    endfunction

    // advance one axis by one screen step
    function automatic void step_axis(
        input  logic [`BLIT_COORD_W-1:0]        sub,
        input  logic [`BLIT_COORD_W-1:0]        ss,
        input  logic signed [`BLIT_COORD_W-1:0] scale,
        output logic [`BLIT_COORD_W-1:0]        sub_n,
        output logic [`BLIT_COORD_W-1:0]        ss_n
    );
        logic [`BLIT_COORD_W-1:0] mag;
        blit_pkg::scale_mode_e    mode;
        mag   = scale_mag(scale);
        mode  = (scale < 0) ? blit_pkg::DOWNSCALE : blit_pkg::UPSCALE;
        sub_n = '0;
        ss_n  = ss + mag;
        if (mode == blit_pkg::UPSCALE) begin
            if (sub == mag - 1'b1) begin
                ss_n = ss + 1'b1;  // next sheet pixel once repeats are done
            end else begin
                sub_n = sub + 1'b1;
                ss_n  = ss;
            end
        end
    endfunction

    always_comb begin
        step_axis(sub_x, ss_x, cmd_q.scale_x, nxt_sub_x, nxt_ss_x);
        step_axis(sub_y, ss_y, cmd_q.scale_y, nxt_sub_y, nxt_ss_y);
    end

    assign max_x     = cmd_q.width - 1'b1;
    assign max_y     = cmd_q.height - 1'b1;
    assign x_end     = (x == max_x);
    assign y_end     = (y == max_y);
    assign cmd_ready = (state == blit_pkg::RECT_IDLE);
    assign pos_valid = (state == blit_pkg::RECT_WALK);
    assign pos_hs    = pos_valid && pos_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= blit_pkg::RECT_IDLE;
        end else if (cmd_valid && cmd_ready) begin
            state <= blit_pkg::RECT_WALK;
        end else if (pos_hs && x_end && y_end) begin
            state <= blit_pkg::RECT_IDLE;  // last position taken
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
            x     <= '0;
            y     <= '0;
            sub_x <= '0;
            sub_y <= '0;
            ss_x  <= cmd.src_x;
            ss_y  <= cmd.src_y;
        end else if (pos_hs) begin
            if (x_end) begin
                x     <= '0;
                sub_x <= '0;
                ss_x  <= cmd_q.src_x;  // back to row start
                y     <= y + 1'b1;
                sub_y <= nxt_sub_y;
                ss_y  <= nxt_ss_y;
            end else begin
                x     <= x + 1'b1;
                sub_x <= nxt_sub_x;
                ss_x  <= nxt_ss_x;
            end
        end
    end

    always_comb begin
        pos.sheet_x     = ss_x;
        pos.sheet_y     = ss_y;
        pos.screen_x    = cmd_q.mirror_x ? cmd_q.dst_x + max_x - x : cmd_q.dst_x + x;
        pos.screen_y    = cmd_q.mirror_y ? cmd_q.dst_y + max_y - y : cmd_q.dst_y + y;
        pos.sheet_base  = cmd_q.sheet_base;
        pos.sheet_width = cmd_q.sheet_width;
        pos.ct_type     = cmd_q.ct_type;
        pos.use_ct      = cmd_q.use_ct;
        pos.last        = x_end && y_end;
    end

    a_pos_stable: assert property (@(posedge clk) disable iff (rst)
        pos_valid && !pos_ready |=> pos_valid && $stable(pos));

endmodule

/* hdl/blit_pkg.sv */
`include "blit_config.svh"

package blit_pkg;

    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } ct_type_e;

    typedef enum logic {
        UPSCALE,    // repeat each sheet pixel
        DOWNSCALE   // skip sheet pixels
    } scale_mode_e;

    typedef enum logic {
        RECT_IDLE,
        RECT_WALK
    } rect_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_HOLD
    } fetch_state_e;

    typedef struct packed {
        logic [`BLIT_ADDR_W-1:0]         sheet_base;   // byte address
        logic [`BLIT_COORD_W-1:0]        sheet_width;  // in pixels
        logic [`BLIT_COORD_W-1:0]        src_x;
        logic [`BLIT_COORD_W-1:0]        src_y;
        logic [`BLIT_COORD_W-1:0]        dst_x;
        logic [`BLIT_COORD_W-1:0]        dst_y;
        logic [`BLIT_COORD_W-1:0]        width;
        logic [`BLIT_COORD_W-1:0]        height;
        logic signed [`BLIT_COORD_W-1:0] scale_x;
        logic signed [`BLIT_COORD_W-1:0] scale_y;
        logic                            mirror_x;
        logic                            mirror_y;
        ct_type_e                        ct_type;
        logic                            use_ct;
    } blit_cmd_t;

    typedef struct packed {
        logic [`BLIT_COORD_W-1:0] sheet_x;
        logic [`BLIT_COORD_W-1:0] sheet_y;
        logic [`BLIT_COORD_W-1:0] screen_x;
        logic [`BLIT_COORD_W-1:0] screen_y;
        logic [`BLIT_ADDR_W-1:0]  sheet_base;
        logic [`BLIT_COORD_W-1:0] sheet_width;
        ct_type_e                 ct_type;
        logic                     use_ct;
        logic                     last;
    } sheet_pos_t;

    typedef struct packed {
        logic [`BLIT_ADDR_W-1:0]  word_addr;
        logic [4:0]               bit_offset;  // lsb of the field in the word
        ct_type_e                 ct_type;
        logic                     use_ct;
        logic [`BLIT_COORD_W-1:0] screen_x;
        logic [`BLIT_COORD_W-1:0] screen_y;
        logic                     last;
    } fetch_req_t;

    typedef struct packed {
        logic [`BLIT_COLOUR_W-1:0] value;  // colour or table index
        logic                      use_ct;
        logic [`BLIT_COORD_W-1:0]  screen_x;
        logic [`BLIT_COORD_W-1:0]  screen_y;
        logic                      last;
    } texel_t;

    typedef struct packed {
        logic [`BLIT_COLOUR_W-1:0] colour;
        logic [`BLIT_COORD_W-1:0]  x;
        logic [`BLIT_COORD_W-1:0]  y;
        logic                      last;
    } pixel_t;

endpackage

/* hdl/blit_config.svh */
`ifndef BLIT_CONFIG_SVH
`define BLIT_CONFIG_SVH

// coordinate and size fields
`define BLIT_COORD_W 16

// byte addresses on the AXI side
`define BLIT_ADDR_W 32

// AXI-lite read data word
`define BLIT_DATA_W 32

// RGB565 colour
`define BLIT_COLOUR_W 16

// colour table size and its index width
`define BLIT_CT_DEPTH 256
`define BLIT_CT_ADDR_W 8

`endif
